//--- common/cpu_defines.svh
`ifndef CPU_DEFINES_SVH
`define CPU_DEFINES_SVH

// Datapath word width
`define XLEN 32

// Register file index width, 32 registers
`define REG_AW 5

// Instruction address width
`define PC_W 12

// Data memory index width, 256 words
`define DMEM_AW 8

`define IMM_W 17
`define STATUS_W 27

// jal writes its return address here
`define LINK_REG 31

`endif

//--- common/cpu_pkg.sv
`default_nettype none

`include "cpu_defines.svh"

package cpu_pkg;

	////////////////////
	// Widths with meaning

	typedef logic [`XLEN-1:0]    word_t;
	typedef logic [`XLEN-1:0]    instr_t;
	typedef logic [`REG_AW-1:0]  reg_idx_t;
	typedef logic [`PC_W-1:0]    pc_t;
	typedef logic [`IMM_W-1:0]   imm_t;
	typedef logic [`STATUS_W-1:0] status_t;
	typedef logic [`DMEM_AW-1:0] dmem_addr_t;

	////////////////////
	// Encodings

	// Instruction bits 31:27
	typedef enum logic [4:0] {
		OP_ARITH = 5'd0,
		OP_J     = 5'd1,
		OP_BNE   = 5'd2,
		OP_JAL   = 5'd3,
		OP_JR    = 5'd4,
		OP_ADDI  = 5'd5,
		OP_BLT   = 5'd6,
		OP_SW    = 5'd7,
		OP_LW    = 5'd8,
		OP_SETX  = 5'd21
	} opcode_e;

	// R-type ALU op, bits 6:2
	typedef enum logic [4:0] {
		ALU_ADD = 5'd0,
		ALU_SUB = 5'd1,
		ALU_AND = 5'd2,
		ALU_OR  = 5'd3,
		ALU_SLL = 5'd4,
		ALU_SRA = 5'd5
	} alu_op_e;

	// Register write-back source
	typedef enum logic [1:0] {
		WB_ALU,
		WB_MEM,
		WB_LINK
	} wb_sel_e;

endpackage

`default_nettype wire

//--- common/ctrl_if.sv
`timescale 1ns/1ns
`default_nettype none

interface ctrl_if;

	// ALU control
	cpu_pkg::alu_op_e  alu_op;
	logic [4:0]        shamt;
	cpu_pkg::word_t    imm;
	logic              use_imm;

	// Register file
	cpu_pkg::reg_idx_t ra_idx;
	cpu_pkg::reg_idx_t rb_idx;
	cpu_pkg::reg_idx_t wr_idx;
	logic              reg_we;
	cpu_pkg::wb_sel_e  wb_sel;

	// Store strobe
	logic              mem_we;

	// Control flow, target also feeds setx
	logic              is_bne;
	logic              is_blt;
	logic              is_j;
	logic              is_jr;
	cpu_pkg::status_t  target;

	// Status register
	logic              ovf_chk;
	logic              setx;

	modport decoder (
		output alu_op, shamt, imm, use_imm, ra_idx, rb_idx, wr_idx, reg_we, wb_sel,
		output mem_we, is_bne, is_blt, is_j, is_jr, target, ovf_chk, setx
	);

	modport datapath (
		input alu_op, shamt, imm, use_imm, ra_idx, rb_idx, wr_idx, reg_we, wb_sel,
		input mem_we, is_bne, is_blt, is_j, is_jr, target, ovf_chk, setx
	);

endinterface

`default_nettype wire

//--- alu/alu.sv
`timescale 1ns/1ns
`default_nettype none

`include "cpu_defines.svh"

module alu (
	input  cpu_pkg::word_t i_a,
	input  cpu_pkg::word_t i_b,
	ctrl_if.datapath       ctl,
	output cpu_pkg::word_t o_result,
	output logic           o_ne,
	output logic           o_lt,
	output logic           o_ovf
);

	cpu_pkg::word_t op_b;
	cpu_pkg::word_t sum;
	cpu_pkg::word_t diff;
	logic           add_ovf;
	logic           sub_ovf;

	// Operand B, immediate for addi, sw and lw
	assign op_b = ctl.use_imm ? ctl.imm : i_b;

	assign sum  = i_a + op_b;
	assign diff = i_a - op_b;

	////////////////////
	// Flags

	// Same-sign inputs, sum flips sign
	assign add_ovf = (i_a[`XLEN-1] == op_b[`XLEN-1]) && (sum[`XLEN-1] != i_a[`XLEN-1]);
	// Opposite signs, difference takes sign of B
	assign sub_ovf = (i_a[`XLEN-1] != op_b[`XLEN-1]) && (diff[`XLEN-1] != i_a[`XLEN-1]);

	assign o_ovf = (ctl.alu_op == cpu_pkg::ALU_SUB) ? sub_ovf : add_ovf;
	assign o_ne  = (diff != '0);
	// Signed less-than, corrected for overflow
	assign o_lt  = diff[`XLEN-1] ^ sub_ovf;

	////////////////////
	// Result select

	always_comb begin
		case (ctl.alu_op)
			cpu_pkg::ALU_ADD: o_result = sum;
			cpu_pkg::ALU_SUB: o_result = diff;
			cpu_pkg::ALU_AND: o_result = i_a & op_b;
			cpu_pkg::ALU_OR:  o_result = i_a | op_b;
			cpu_pkg::ALU_SLL: o_result = i_a << ctl.shamt;
			cpu_pkg::ALU_SRA: o_result = cpu_pkg::word_t'($signed(i_a) >>> ctl.shamt);
			default:          o_result = '0;
		endcase
	end

	// Store address must fit in data memory
	always_comb begin
		if (ctl.mem_we) begin
			assert final (o_result[`XLEN-1:`DMEM_AW] == '0)
				else $error("store address %h out of data memory", o_result);
		end
	end

endmodule

`default_nettype wire

//--- verilog/instr_decoder.sv
`timescale 1ns/1ns
`default_nettype none

`include "cpu_defines.svh"

module instr_decoder (
	input  cpu_pkg::instr_t i_instr,
	ctrl_if.decoder         ctl
);

	cpu_pkg::opcode_e  opcode;
	cpu_pkg::alu_op_e  r_alu_op;
	cpu_pkg::reg_idx_t rd;
	cpu_pkg::reg_idx_t rs;
	cpu_pkg::reg_idx_t rt;
	cpu_pkg::imm_t     imm_raw;

	////////////////////
	// Field split

	assign opcode   = cpu_pkg::opcode_e'(i_instr[31:27]);
	assign rd       = i_instr[26:22];
	assign rs       = i_instr[21:17];
	assign rt       = i_instr[16:12];
	assign r_alu_op = cpu_pkg::alu_op_e'(i_instr[6:2]);
	assign imm_raw  = i_instr[16:0];

	assign ctl.shamt  = i_instr[11:7];
	assign ctl.target = i_instr[26:0];
	assign ctl.imm    = {{(`XLEN-`IMM_W){imm_raw[`IMM_W-1]}}, imm_raw};

	////////////////////
	// Control

	always_comb begin
		// Defaults give a no-op
		ctl.alu_op  = cpu_pkg::ALU_ADD;
		ctl.use_imm = 1'b0;
		ctl.ra_idx  = rs;
		ctl.rb_idx  = rt;
		ctl.wr_idx  = rd;
		ctl.reg_we  = 1'b0;
		ctl.wb_sel  = cpu_pkg::WB_ALU;
		ctl.mem_we  = 1'b0;
		ctl.is_bne  = 1'b0;
		ctl.is_blt  = 1'b0;
		ctl.is_j    = 1'b0;
		ctl.is_jr   = 1'b0;
		ctl.ovf_chk = 1'b0;
		ctl.setx    = 1'b0;

		case (opcode)
			cpu_pkg::OP_ARITH: begin
				ctl.alu_op  = r_alu_op;
				ctl.reg_we  = 1'b1;
				ctl.ovf_chk = (r_alu_op == cpu_pkg::ALU_ADD) || (r_alu_op == cpu_pkg::ALU_SUB);
			end
			cpu_pkg::OP_ADDI: begin
				ctl.use_imm = 1'b1;
				ctl.reg_we  = 1'b1;
				ctl.ovf_chk = 1'b1;
			end
			// Address is $rs + imm, store data rides on port B
			cpu_pkg::OP_SW: begin
				ctl.use_imm = 1'b1;
				ctl.rb_idx  = rd;
				ctl.mem_we  = 1'b1;
			end
			cpu_pkg::OP_LW: begin
				ctl.use_imm = 1'b1;
				ctl.rb_idx  = rd;
				ctl.reg_we  = 1'b1;
				ctl.wb_sel  = cpu_pkg::WB_MEM;
			end
			cpu_pkg::OP_J: ctl.is_j = 1'b1;
			cpu_pkg::OP_JAL: begin
				ctl.is_j   = 1'b1;
				ctl.reg_we = 1'b1;
				ctl.wr_idx = cpu_pkg::reg_idx_t'(`LINK_REG);
				ctl.wb_sel = cpu_pkg::WB_LINK;
			end
			cpu_pkg::OP_JR: begin
				ctl.is_jr  = 1'b1;
				ctl.ra_idx = rd;
			end
			// Branches compare $rd against $rs
			cpu_pkg::OP_BNE, cpu_pkg::OP_BLT: begin
				ctl.alu_op = cpu_pkg::ALU_SUB;
				ctl.ra_idx = rd;
				ctl.rb_idx = rs;
				ctl.is_bne = (opcode == cpu_pkg::OP_BNE);
				ctl.is_blt = (opcode == cpu_pkg::OP_BLT);
			end
			cpu_pkg::OP_SETX: ctl.setx = 1'b1;
			default: ;
		endcase
	end

	// A store never also writes a register
	always_comb begin
		assert final (!(ctl.mem_we && ctl.reg_we))
			else $error("decoder drives mem_we and reg_we together");
	end

endmodule

`default_nettype wire

//--- verilog/reg_file.sv
`timescale 1ns/1ns
`default_nettype none

`include "cpu_defines.svh"

module reg_file (
	input  logic             i_clk,
	input  logic             i_rst_n,
	ctrl_if.datapath         ctl,
	input  cpu_pkg::word_t   i_wdata,
	input  cpu_pkg::word_t   i_mem_rdata,
	input  cpu_pkg::pc_t     i_pc_plus_one,
	input  logic             i_alu_ovf,
	output cpu_pkg::word_t   o_rdata_a,
	output cpu_pkg::word_t   o_rdata_b,
	output cpu_pkg::status_t o_status
);

	cpu_pkg::word_t   regs [2**`REG_AW];
	cpu_pkg::word_t   wb_data;
	cpu_pkg::status_t status_q;

	////////////////////
	// Write-back

	// i_wdata is the ALU result
	always_comb begin
		case (ctl.wb_sel)
			cpu_pkg::WB_MEM:  wb_data = i_mem_rdata;
			cpu_pkg::WB_LINK: wb_data = {{(`XLEN-`PC_W){1'b0}}, i_pc_plus_one};
			default:          wb_data = i_wdata;
		endcase
	end

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			for (int i = 0; i < 2**`REG_AW; i++) begin
				regs[i] <= '0;
			end
		end else if (ctl.reg_we && (ctl.wr_idx != '0)) begin
			regs[ctl.wr_idx] <= wb_data;
		end
	end

	// Register 0 reads as zero
	assign o_rdata_a = (ctl.ra_idx == '0) ? '0 : regs[ctl.ra_idx];
	assign o_rdata_b = (ctl.rb_idx == '0) ? '0 : regs[ctl.rb_idx];

	////////////////////
	// Status register

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			status_q <= '0;
		end else if (ctl.setx) begin
			status_q <= ctl.target;
		end else if (ctl.ovf_chk) begin
			status_q <= {{(`STATUS_W-1){1'b0}}, i_alu_ovf};
		end
	end

	assign o_status = status_q;

	a_reg0_zero: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		regs[0] == '0)
		else $error("register 0 was written");

endmodule

`default_nettype wire

//--- verilog/pc_unit.sv
`timescale 1ns/1ns
`default_nettype none

`include "cpu_defines.svh"

module pc_unit (
	input  logic           i_clk,
	input  logic           i_rst_n,
	ctrl_if.datapath       ctl,
	input  logic           i_ne,
	input  logic           i_lt,
	input  cpu_pkg::word_t i_jr_addr,
	output cpu_pkg::pc_t   o_pc,
	output cpu_pkg::pc_t   o_pc_plus_one
);

	cpu_pkg::pc_t pc_q;
	cpu_pkg::pc_t pc_next;
	cpu_pkg::pc_t pc_branch;
	logic         taken;

	assign o_pc_plus_one = pc_q + 1'b1;
	// Branch offset is relative to PC+1
	assign pc_branch     = o_pc_plus_one + ctl.imm[`PC_W-1:0];

	// Only place a branch condition is tested
	assign taken = (ctl.is_bne && i_ne) || (ctl.is_blt && i_lt);

	always_comb begin
		if (ctl.is_jr) begin
			pc_next = i_jr_addr[`PC_W-1:0];
		end else if (ctl.is_j) begin
			pc_next = ctl.target[`PC_W-1:0];
		end else if (taken) begin
			pc_next = pc_branch;
		end else begin
			pc_next = o_pc_plus_one;
		end
	end

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			pc_q <= '0;
		end else begin
			pc_q <= pc_next;
		end
	end

	assign o_pc = pc_q;

	a_pc_step: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		!(ctl.is_j || ctl.is_jr || ctl.is_bne || ctl.is_blt) |=> o_pc == $past(o_pc_plus_one))
		else $error("PC did not step by one");

endmodule

`default_nettype wire

//--- verilog/data_mem.sv
`timescale 1ns/1ns
`default_nettype none

`include "cpu_defines.svh"

module data_mem (
	input  logic               i_clk,
	input  logic               i_rst_n,
	ctrl_if.datapath           ctl,
	input  cpu_pkg::dmem_addr_t i_addr,
	input  cpu_pkg::word_t     i_wdata,
	output cpu_pkg::word_t     o_rdata
);

	cpu_pkg::word_t mem [2**`DMEM_AW];

	// Store lands at the edge ending the sw
	always_ff @(posedge i_clk) begin
		if (i_rst_n && ctl.mem_we) begin
			mem[i_addr] <= i_wdata;
		end
	end

	// Load data same cycle
	assign o_rdata = mem[i_addr];

endmodule

`default_nettype wire

//--- verilog/cpu_top.sv
`timescale 1ns/1ns
`default_nettype none

`include "cpu_defines.svh"

module cpu_top (
	input  logic                i_clk,
	input  logic                i_rst_n,
	input  cpu_pkg::instr_t     i_instr,
	output cpu_pkg::pc_t        o_pc,
	output logic                o_dmem_we,
	output cpu_pkg::dmem_addr_t o_dmem_addr,
	output cpu_pkg::word_t      o_dmem_wdata,
	output cpu_pkg::status_t    o_status
);

	cpu_pkg::word_t rdata_a;
	cpu_pkg::word_t rdata_b;
	cpu_pkg::word_t alu_result;
	cpu_pkg::word_t mem_rdata;
	cpu_pkg::pc_t   pc_plus_one;
	logic           alu_ne;
	logic           alu_lt;
	logic           alu_ovf;

	ctrl_if ctl ();

	////////////////////
	// Control

	instr_decoder decoder_i (
		.i_instr (i_instr),
		.ctl     (ctl.decoder)
	);

	////////////////////
	// Datapath

	alu alu_i (
		.i_a      (rdata_a),
		.i_b      (rdata_b),
		.ctl      (ctl.datapath),
		.o_result (alu_result),
		.o_ne     (alu_ne),
		.o_lt     (alu_lt),
		.o_ovf    (alu_ovf)
	);

	reg_file reg_file_i (
		.i_clk         (i_clk),
		.i_rst_n       (i_rst_n),
		.ctl           (ctl.datapath),
		.i_wdata       (alu_result),
		.i_mem_rdata   (mem_rdata),
		.i_pc_plus_one (pc_plus_one),
		.i_alu_ovf     (alu_ovf),
		.o_rdata_a     (rdata_a),
		.o_rdata_b     (rdata_b),
		.o_status      (o_status)
	);

	// jr target comes from read port A
	pc_unit pc_unit_i (
		.i_clk         (i_clk),
		.i_rst_n       (i_rst_n),
		.ctl           (ctl.datapath),
		.i_ne          (alu_ne),
		.i_lt          (alu_lt),
		.i_jr_addr     (rdata_a),
		.o_pc          (o_pc),
		.o_pc_plus_one (pc_plus_one)
	);

	data_mem data_mem_i (
		.i_clk   (i_clk),
		.i_rst_n (i_rst_n),
		.ctl     (ctl.datapath),
		.i_addr  (o_dmem_addr),
		.i_wdata (rdata_b),
		.o_rdata (mem_rdata)
	);

	// Store port, valid during the sw cycle
	assign o_dmem_addr  = alu_result[`DMEM_AW-1:0];
	assign o_dmem_wdata = rdata_b;
	assign o_dmem_we    = ctl.mem_we & i_rst_n;

endmodule

`default_nettype wire

//--- dv/cpu_tb.sv
`timescale 1ns/1ns
`default_nettype none

module cpu_tb;

	localparam int CLK_HALF     = 10;
	localparam int DRIVE_DLY    = 2;
	localparam int RESET_CYCLES = 16;
	localparam int MAX_STEPS    = 256;
	localparam int MAX_STORES   = 64;
	localparam int HALT_TIMEOUT = 400;
	localparam int SUB_ADDR     = 64;

	logic                i_clk;
	logic                i_rst_n;
	cpu_pkg::instr_t     i_instr;
	cpu_pkg::pc_t        o_pc;
	logic                o_dmem_we;
	cpu_pkg::dmem_addr_t o_dmem_addr;
	cpu_pkg::word_t      o_dmem_wdata;
	cpu_pkg::status_t    o_status;

	// Instruction ROM and expected trace
	cpu_pkg::instr_t     rom [4096];
	cpu_pkg::pc_t        exp_pc [MAX_STEPS];
	logic                exp_we [MAX_STEPS];
	cpu_pkg::status_t    exp_status [MAX_STEPS];
	cpu_pkg::dmem_addr_t exp_st_addr [MAX_STORES];
	cpu_pkg::word_t      exp_st_data [MAX_STORES];
	int                  n_steps;
	int                  n_stores;
	int                  prog_len;
	int                  step;
	int                  store_idx;

	cpu_top cpu_top_i (
		.i_clk        (i_clk),
		.i_rst_n      (i_rst_n),
		.i_instr      (i_instr),
		.o_pc         (o_pc),
		.o_dmem_we    (o_dmem_we),
		.o_dmem_addr  (o_dmem_addr),
		.o_dmem_wdata (o_dmem_wdata),
		.o_status     (o_status)
	);

	initial i_clk = 1'b0;
	always #CLK_HALF i_clk = ~i_clk;

	// Fetch from the ROM once the new PC has settled
	always @(posedge i_clk) begin
		#DRIVE_DLY;
		if (i_rst_n) begin
			i_instr = rom[o_pc];
		end
	end

	always @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			step      <= 0;
			store_idx <= 0;
		end else begin
			if (step < n_steps) begin
				step <= step + 1;
			end
			if (o_dmem_we) begin
				store_idx <= store_idx + 1;
			end
		end
	end

	task automatic fail_now(string what);
		$display("%s", what);
		$display("*** TEST FAILED ***");
		$fatal(1);
	endtask

	task automatic mismatch(string test, logic [31:0] expected, logic [31:0] actual);
		fail_now($sformatf("MISMATCH %s expected %h actual %h", test, expected, actual));
	endtask

	////////////////////
	// Instruction encoding

	function automatic cpu_pkg::instr_t arith_instr(cpu_pkg::alu_op_e op, int rd, int rs,
		int rt, int sh);
		return {cpu_pkg::OP_ARITH, 5'(rd), 5'(rs), 5'(rt), 5'(sh), op, 2'b00};
	endfunction

	function automatic cpu_pkg::instr_t imm_instr(cpu_pkg::opcode_e op, int rd, int rs, int imm);
		return {op, 5'(rd), 5'(rs), 17'(imm)};
	endfunction

	function automatic cpu_pkg::instr_t jump_instr(cpu_pkg::opcode_e op, int target);
		return {op, 27'(target)};
	endfunction

	function automatic logic signed_ovf(cpu_pkg::word_t a, cpu_pkg::word_t b, logic sub);
		longint         wide;
		cpu_pkg::word_t narrow;
		wide = sub ? longint'($signed(a)) - longint'($signed(b))
			: longint'($signed(a)) + longint'($signed(b));
		narrow = cpu_pkg::word_t'(wide);
		return wide != longint'($signed(narrow));
	endfunction

	task automatic put_instr(cpu_pkg::instr_t instr);
		rom[prog_len] = instr;
		prog_len++;
	endtask

	////////////////////
	// Program

	task automatic load_program();
		// Unused slots park the PC on themselves
		foreach (rom[i]) begin
			rom[i] = jump_instr(cpu_pkg::OP_J, i);
		end
		put_instr(imm_instr(cpu_pkg::OP_ADDI, 1, 0, int'($urandom())));
		put_instr(imm_instr(cpu_pkg::OP_ADDI, 2, 0, int'($urandom())));
		put_instr(arith_instr(cpu_pkg::ALU_ADD, 3, 1, 2, 0));
		put_instr(imm_instr(cpu_pkg::OP_SW, 3, 0, 0));
		put_instr(arith_instr(cpu_pkg::ALU_SUB, 4, 1, 2, 0));
		put_instr(imm_instr(cpu_pkg::OP_SW, 4, 0, 1));
		put_instr(arith_instr(cpu_pkg::ALU_AND, 5, 1, 2, 0));
		put_instr(imm_instr(cpu_pkg::OP_SW, 5, 0, 2));
		put_instr(arith_instr(cpu_pkg::ALU_OR, 6, 1, 2, 0));
		put_instr(imm_instr(cpu_pkg::OP_SW, 6, 0, 3));
		put_instr(arith_instr(cpu_pkg::ALU_SLL, 7, 1, 0, int'($urandom() % 31) + 1));
		put_instr(imm_instr(cpu_pkg::OP_SW, 7, 0, 4));
		put_instr(arith_instr(cpu_pkg::ALU_SRA, 8, 2, 0, int'($urandom() % 31) + 1));
		put_instr(imm_instr(cpu_pkg::OP_SW, 8, 0, 5));
		// Store, load back, store again
		put_instr(imm_instr(cpu_pkg::OP_ADDI, 10, 0, 16));
		put_instr(imm_instr(cpu_pkg::OP_SW, 3, 10, 4));
		put_instr(imm_instr(cpu_pkg::OP_LW, 9, 10, 4));
		put_instr(imm_instr(cpu_pkg::OP_SW, 9, 10, 5));
		// Branches, each one followed by a marker store
		put_instr(imm_instr(cpu_pkg::OP_ADDI, 11, 0, 5));
		put_instr(imm_instr(cpu_pkg::OP_ADDI, 12, 0, -3));
		put_instr(imm_instr(cpu_pkg::OP_BNE, 11, 12, 1));
		put_instr(imm_instr(cpu_pkg::OP_SW, 11, 0, 30));
		put_instr(imm_instr(cpu_pkg::OP_BNE, 11, 11, 1));
		put_instr(imm_instr(cpu_pkg::OP_SW, 11, 0, 31));
		put_instr(imm_instr(cpu_pkg::OP_BLT, 12, 11, 1));
		put_instr(imm_instr(cpu_pkg::OP_SW, 12, 0, 32));
		put_instr(imm_instr(cpu_pkg::OP_BLT, 11, 12, 1));
		put_instr(imm_instr(cpu_pkg::OP_SW, 12, 0, 33));
		put_instr(jump_instr(cpu_pkg::OP_J, prog_len + 2));
		put_instr(imm_instr(cpu_pkg::OP_SW, 1, 0, 34));
		put_instr(jump_instr(cpu_pkg::OP_JAL, SUB_ADDR));
		// Status: overflow, clear, add overflow, clear, setx
		put_instr(imm_instr(cpu_pkg::OP_ADDI, 13, 0, 1));
		put_instr(arith_instr(cpu_pkg::ALU_SLL, 14, 13, 0, 31));
		put_instr(imm_instr(cpu_pkg::OP_ADDI, 15, 14, -1));
		put_instr(imm_instr(cpu_pkg::OP_ADDI, 16, 0, 0));
		put_instr(arith_instr(cpu_pkg::ALU_ADD, 17, 15, 13, 0));
		put_instr(imm_instr(cpu_pkg::OP_ADDI, 18, 0, 7));
		put_instr(jump_instr(cpu_pkg::OP_SETX, int'($urandom())));
		put_instr(jump_instr(cpu_pkg::OP_J, prog_len));
		// Subroutine saves the link register and returns
		rom[SUB_ADDR]     = imm_instr(cpu_pkg::OP_SW, 31, 0, 40);
		rom[SUB_ADDR + 1] = imm_instr(cpu_pkg::OP_JR, 31, 0, 0);
	endtask

	////////////////////
	// Reference model

	task automatic build_expected();
		cpu_pkg::word_t      regs [32];
		cpu_pkg::word_t      dmem [256];
		cpu_pkg::pc_t        pc;
		cpu_pkg::pc_t        pc_next;
		cpu_pkg::status_t    status;
		cpu_pkg::instr_t     ins;
		cpu_pkg::word_t      imm;
		cpu_pkg::word_t      wr_val;
		cpu_pkg::dmem_addr_t addr;
		int                  rd;
		int                  rs;
		int                  rt;
		int                  wr_idx;
		logic                wr_en;
		logic                chk;
		logic                ovf;

		pc = '0;
		status = '0;
		n_stores = 0;
		n_steps = -1;
		foreach (regs[i]) begin
			regs[i] = '0;
		end
		for (int k = 0; k < MAX_STEPS && n_steps < 0; k++) begin
			ins = rom[pc];
			rd = ins[26:22];
			rs = ins[21:17];
			rt = ins[16:12];
			imm = {{15{ins[16]}}, ins[16:0]};
			exp_pc[k] = pc;
			exp_status[k] = status;
			exp_we[k] = 1'b0;
			pc_next = pc + 12'd1;
			wr_en = 1'b0;
			wr_idx = rd;
			wr_val = '0;
			chk = 1'b0;
			ovf = 1'b0;
			case (ins[31:27])
				cpu_pkg::OP_ARITH: begin
					wr_en = 1'b1;
					chk = (ins[6:2] == cpu_pkg::ALU_ADD) || (ins[6:2] == cpu_pkg::ALU_SUB);
					ovf = signed_ovf(regs[rs], regs[rt], ins[6:2] == cpu_pkg::ALU_SUB);
					case (ins[6:2])
						cpu_pkg::ALU_ADD: wr_val = regs[rs] + regs[rt];
						cpu_pkg::ALU_SUB: wr_val = regs[rs] - regs[rt];
						cpu_pkg::ALU_AND: wr_val = regs[rs] & regs[rt];
						cpu_pkg::ALU_OR:  wr_val = regs[rs] | regs[rt];
						cpu_pkg::ALU_SLL: wr_val = regs[rs] << ins[11:7];
						cpu_pkg::ALU_SRA: wr_val = $signed(regs[rs]) >>> ins[11:7];
						default:          wr_val = '0;
					endcase
				end
				cpu_pkg::OP_ADDI: begin
					wr_en = 1'b1;
					wr_val = regs[rs] + imm;
					chk = 1'b1;
					ovf = signed_ovf(regs[rs], imm, 1'b0);
				end
				cpu_pkg::OP_SW: begin
					addr = cpu_pkg::dmem_addr_t'(regs[rs] + imm);
					dmem[addr] = regs[rd];
					exp_we[k] = 1'b1;
					exp_st_addr[n_stores] = addr;
					exp_st_data[n_stores] = regs[rd];
					n_stores++;
				end
				cpu_pkg::OP_LW: begin
					wr_en = 1'b1;
					wr_val = dmem[cpu_pkg::dmem_addr_t'(regs[rs] + imm)];
				end
				cpu_pkg::OP_J: pc_next = cpu_pkg::pc_t'(ins[26:0]);
				cpu_pkg::OP_JAL: begin
					wr_en = 1'b1;
					wr_idx = 31;
					wr_val = {20'd0, pc + 12'd1};
					pc_next = cpu_pkg::pc_t'(ins[26:0]);
				end
				cpu_pkg::OP_JR: pc_next = cpu_pkg::pc_t'(regs[rd]);
				cpu_pkg::OP_BNE: begin
					if (regs[rd] != regs[rs]) begin
						pc_next = pc + 12'd1 + cpu_pkg::pc_t'(imm);
					end
				end
				cpu_pkg::OP_BLT: begin
					if ($signed(regs[rd]) < $signed(regs[rs])) begin
						pc_next = pc + 12'd1 + cpu_pkg::pc_t'(imm);
					end
				end
				cpu_pkg::OP_SETX: status = ins[26:0];
				default: ;
			endcase
			if (chk) begin
				status = cpu_pkg::status_t'(ovf);
			end
			if (wr_en && wr_idx != 0) begin
				regs[wr_idx] = wr_val;
			end
			if (pc_next == pc) begin
				n_steps = k;
			end
			pc = pc_next;
		end
		if (n_steps < 0) begin
			fail_now("reference model never reached a self-loop jump");
		end
	endtask

	////////////////////
	// Checks

	a_reset_idle: assert property (@(posedge i_clk)
		!i_rst_n |-> (o_pc == '0 && !o_dmem_we && o_status == '0))
		else fail_now("outputs are not idle while reset is asserted");

	a_pc_trace: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		o_pc == exp_pc[step])
		else mismatch("pc_trace", exp_pc[$sampled(step)], $sampled(o_pc));

	a_store_strobe: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		o_dmem_we == exp_we[step])
		else mismatch("store_strobe", exp_we[$sampled(step)], $sampled(o_dmem_we));

	a_store_addr: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		o_dmem_we |-> o_dmem_addr == exp_st_addr[store_idx])
		else mismatch("store_addr", exp_st_addr[$sampled(store_idx)], $sampled(o_dmem_addr));

	a_store_data: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		o_dmem_we |-> o_dmem_wdata == exp_st_data[store_idx])
		else mismatch("store_data", exp_st_data[$sampled(store_idx)], $sampled(o_dmem_wdata));

	a_status: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		o_status == exp_status[step])
		else mismatch("status", exp_status[$sampled(step)], $sampled(o_status));

	initial begin
		int cycles;

		i_rst_n = 1'b1;
		i_instr = '0;
		n_steps = 0;
		prog_len = 0;
		void'($urandom(32'h4902df34));
		load_program();
		build_expected();
		// Falling edge so the async reset fires
		#1;
		i_rst_n = 1'b0;
		// A store sits on the fetch port until reset lets go
		i_instr = imm_instr(cpu_pkg::OP_SW, 0, 0, 0);
		repeat (RESET_CYCLES) @(posedge i_clk);
		#DRIVE_DLY;
		i_rst_n = 1'b1;
		i_instr = rom[o_pc];
		cycles = 0;
		while (step < n_steps && cycles < HALT_TIMEOUT) begin
			@(posedge i_clk);
			cycles++;
		end
		if (step < n_steps) begin
			fail_now("timeout waiting for the program to reach its halt loop");
		end
		// Sit in the halt loop for a few cycles
		repeat (4) @(posedge i_clk);
		#DRIVE_DLY;
		if (store_idx == n_stores) begin
			$display("*** TEST PASSED ***");
			$finish;
		end else begin
			fail_now($sformatf("saw %0d stores but %0d were expected", store_idx, n_stores));
		end
	end

endmodule

`default_nettype wire

//--- build.f
+incdir+common
common/cpu_pkg.sv
common/ctrl_if.sv
alu/alu.sv
verilog/instr_decoder.sv
verilog/reg_file.sv
verilog/pc_unit.sv
verilog/data_mem.sv
verilog/cpu_top.sv
dv/cpu_tb.sv

//--- Bender.yml
package:
  name: cpu_top

export_include_dirs:
  - common

sources:
  - include_dirs:
      - common
    files:
      - common/cpu_pkg.sv
      - common/ctrl_if.sv
      - alu/alu.sv
      - verilog/instr_decoder.sv
      - verilog/reg_file.sv
      - verilog/pc_unit.sv
      - verilog/data_mem.sv
      - verilog/cpu_top.sv
  - target: simulation
    files:
      - dv/cpu_tb.sv
